// ==== common/bayes_pkg.sv ====
package bayes_pkg;

    //==========================================================================
    // widths and sizes
    //==========================================================================
    localparam int N_CLASS      = 3;
    localparam int VOCAB_W      = 4;   // table index bits taken from a word byte
    localparam int SUM_W        = 24;  // log_w accumulator width
    localparam int RX_DEPTH_LOG = 4;
    localparam int TX_DEPTH_LOG = 4;

    typedef logic [7:0]         byte_t;
    typedef logic [VOCAB_W-1:0] word_idx_t;
    typedef logic [15:0]        log_w_t;
    typedef logic [31:0]        score_t;
    typedef logic [1:0]         class_t;

    //==========================================================================
    // byte protocol
    //==========================================================================
    localparam byte_t START_MARK = 8'hff;
    localparam byte_t END_MARK   = 8'hfe;
    localparam byte_t PING_MARK  = 8'hfd;
    localparam byte_t PING_REPLY = 8'h57;

    // cycles to wait after END so the last word reaches the sum
    localparam int SETTLE_CYCLES = 2;

    //==========================================================================
    // per-class model constants
    //==========================================================================
    localparam score_t LOG_D [N_CLASS] = '{32'd96, 32'd140, 32'd75};
    localparam score_t LOG_V [N_CLASS] = '{32'd420, 32'd390, 32'd450};

    // 16 entries per class, class 0 first
    localparam string LOG_W_FILE = "common/log_w.hex";

endpackage

// ==== common/word_if.sv ====
`timescale 1ns/1ns

// word stream from the frame controller to every class scorer
interface word_if import bayes_pkg::*; ();

    logic  start;   // pulse when the parameter byte is taken
    logic  enable;  // one strobe per word
    byte_t word;
    byte_t amount;  // word count N, held for the frame

    modport controller (
        output start,
        output enable,
        output word,
        output amount
    );

    modport scorer (
        input start,
        input enable,
        input word,
        input amount
    );

endinterface

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter int DATA_W    = 8,
    parameter int DEPTH_LOG = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  logic [DATA_W-1:0] wdata,
    output logic              full,
    input  logic              re,
    output logic [DATA_W-1:0] rdata,
    output logic              empty
);

    logic [DATA_W-1:0]  mem [2**DEPTH_LOG];
    logic [DEPTH_LOG:0] wptr;  // msb is the wrap bit
    logic [DEPTH_LOG:0] rptr;
    logic               do_write;
    logic               do_read;

    assign do_write = we && !full;
    assign do_read  = re && !empty;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_write)
                wptr <= wptr + 1'b1;
            if (do_read)
                rptr <= rptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wptr[DEPTH_LOG-1:0]] <= wdata;
        if (do_read)
            rdata <= mem[rptr[DEPTH_LOG-1:0]];  // valid the cycle after the pop
    end

    // same slot, wrap bits differ -> one lap ahead
    assign empty = (wptr == rptr);
    assign full  = (wptr[DEPTH_LOG] != rptr[DEPTH_LOG]) &&
                   (wptr[DEPTH_LOG-1:0] == rptr[DEPTH_LOG-1:0]);

endmodule

// ==== controller/frame_controller.sv ====
`timescale 1ns/1ns

module frame_controller import bayes_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_empty,
    output logic       rx_re,
    input  byte_t      rx_data,
    input  logic       tx_full,
    output logic       tx_we,
    output byte_t      tx_data,
    word_if.controller words,
    input  class_t     class_win
);

    typedef enum logic [2:0] {
        st_idle,
        st_param,
        st_words,
        st_settle,
        st_reply,
        st_ping
    } state_t;

    state_t     state;
    logic       byte_valid;  // rx_data holds the byte popped last cycle
    logic       reading;
    logic       settle_done;
    logic [1:0] cnt;         // settle wait, then reply byte index
    class_t     win_q;

    //==========================================================================
    // receive side, one byte in flight at a time
    //==========================================================================
    assign reading = (state == st_idle) || (state == st_param) || (state == st_words);
    assign rx_re   = reading && !rx_empty && !byte_valid;

    always_ff @(posedge clk) begin
        if (!rst)
            byte_valid <= 1'b0;
        else
            byte_valid <= rx_re;
    end

    assign settle_done = (state == st_settle) && (cnt == 2'(SETTLE_CYCLES - 1));

    //==========================================================================
    // protocol FSM
    //==========================================================================
    always_ff @(posedge clk) begin
        if (!rst) begin
            state        <= st_idle;
            cnt          <= '0;
            words.start  <= 1'b0;
            words.enable <= 1'b0;
        end else begin
            words.start  <= 1'b0;
            words.enable <= 1'b0;
            case (state)
                st_idle: begin
                    if (byte_valid && rx_data == START_MARK)
                        state <= st_param;
                    else if (byte_valid && rx_data == PING_MARK)
                        state <= st_ping;
                end
                st_param: begin
                    if (byte_valid) begin
                        words.start <= 1'b1;  // scorers clear their sums
                        state       <= st_words;
                    end
                end
                st_words: begin
                    if (byte_valid && rx_data == END_MARK) begin
                        state <= st_settle;
                        cnt   <= '0;
                    end else if (byte_valid) begin
                        words.enable <= 1'b1;
                    end
                end
                st_settle: begin
                    if (settle_done) begin
                        state <= st_reply;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 2'd1;
                    end
                end
                st_reply: begin
                    if (!tx_full && cnt == 2'd2) begin
                        state <= st_idle;
                        cnt   <= '0;
                    end else if (!tx_full) begin
                        cnt <= cnt + 2'd1;
                    end
                end
                st_ping: begin
                    if (!tx_full)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid && state == st_param)
            words.amount <= rx_data;
        if (byte_valid && state == st_words)
            words.word <= rx_data;
        if (settle_done)
            win_q <= class_win;  // sums have settled by now
    end

    // reply bytes, held while the tx FIFO is full
    assign tx_we = ((state == st_reply) || (state == st_ping)) && !tx_full;

    always_comb begin
        if (state == st_ping)
            tx_data = PING_REPLY;
        else if (cnt == 2'd0)
            tx_data = START_MARK;
        else if (cnt == 2'd1)
            tx_data = byte_t'(win_q);
        else
            tx_data = END_MARK;
    end

endmodule

// ==== classifier/class_scorer.sv ====
`timescale 1ns/1ns

module class_scorer import bayes_pkg::*; #(
    parameter int CLASS_ID = 0
) (
    input  logic   clk,
    input  logic   rst,
    word_if.scorer words,
    output score_t score
);

    log_w_t           rom [N_CLASS << VOCAB_W];  // whole file, this class uses its slice
    log_w_t           rom_q;
    logic             en_q;
    word_idx_t        idx;
    logic [SUM_W-1:0] sum_q;

    initial begin
        $readmemh(LOG_W_FILE, rom);
    end

    assign idx = words.word[VOCAB_W-1:0];  // low bits only

    always_ff @(posedge clk) begin
        if (words.enable)
            rom_q <= rom[CLASS_ID * (1 << VOCAB_W) + int'(idx)];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            en_q  <= 1'b0;
            sum_q <= '0;
        end else begin
            en_q <= words.enable;
            if (words.start)
                sum_q <= '0;  // new frame
            else if (en_q)
                sum_q <= sum_q + SUM_W'(rom_q);
        end
    end

    // N*log_V - log_D - sum, wraps mod 2^32
    assign score = score_t'(words.amount) * LOG_V[CLASS_ID] - LOG_D[CLASS_ID]
                 - score_t'(sum_q);

endmodule

// ==== classifier/min_tree.sv ====
`timescale 1ns/1ns

module min_tree import bayes_pkg::*; #(
    parameter int LEAVES = N_CLASS,
    parameter int BASE   = 0
) (
    input  score_t scores [LEAVES],
    output class_t class_win,
    output score_t best
);

    if (LEAVES == 1) begin : g_leaf
        assign best      = scores[0];
        assign class_win = class_t'(BASE);
    end else begin : g_node
        score_t left_scores  [LEAVES/2];
        score_t right_scores [LEAVES - LEAVES/2];
        score_t left_best;
        score_t right_best;
        class_t left_win;
        class_t right_win;
        logic   take_left;

        // split into lower and upper halves
        always_comb begin
            for (int i = 0; i < LEAVES/2; i++)
                left_scores[i] = scores[i];
            for (int i = 0; i < LEAVES - LEAVES/2; i++)
                right_scores[i] = scores[LEAVES/2 + i];
        end

        min_tree #(.LEAVES(LEAVES/2), .BASE(BASE)) left_i (
            .scores    (left_scores),
            .class_win (left_win),
            .best      (left_best)
        );

        min_tree #(.LEAVES(LEAVES - LEAVES/2), .BASE(BASE + LEAVES/2)) right_i (
            .scores    (right_scores),
            .class_win (right_win),
            .best      (right_best)
        );

        assign take_left = (left_best < right_best);  // tie goes right
        assign best      = take_left ? left_best : right_best;
        assign class_win = take_left ? left_win : right_win;
    end

endmodule

// ==== source/bayes_classifier.sv ====
`timescale 1ns/1ns

module bayes_classifier import bayes_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  in_we,
    input  byte_t in_data,
    output logic  in_full,
    input  logic  out_re,
    output byte_t out_data,
    output logic  out_empty
);

    logic   rx_re;
    logic   rx_empty;
    byte_t  rx_data;
    logic   tx_we;
    logic   tx_full;
    byte_t  tx_data;
    class_t class_win;
    score_t scores [N_CLASS];

    word_if words_bus ();

    // host -> controller
    sync_fifo #(.DATA_W(8), .DEPTH_LOG(RX_DEPTH_LOG)) rx_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .we    (in_we),
        .wdata (in_data),
        .full  (in_full),
        .re    (rx_re),
        .rdata (rx_data),
        .empty (rx_empty)
    );

    // controller -> host
    sync_fifo #(.DATA_W(8), .DEPTH_LOG(TX_DEPTH_LOG)) tx_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .we    (tx_we),
        .wdata (tx_data),
        .full  (tx_full),
        .re    (out_re),
        .rdata (out_data),
        .empty (out_empty)
    );

    frame_controller ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .rx_empty  (rx_empty),
        .rx_re     (rx_re),
        .rx_data   (rx_data),
        .tx_full   (tx_full),
        .tx_we     (tx_we),
        .tx_data   (tx_data),
        .words     (words_bus.controller),
        .class_win (class_win)
    );

    for (genvar g = 0; g < N_CLASS; g++) begin : g_scorer
        class_scorer #(.CLASS_ID(g)) scorer_i (
            .clk   (clk),
            .rst   (rst),
            .words (words_bus.scorer),
            .score (scores[g])
        );
    end

    min_tree #(.LEAVES(N_CLASS), .BASE(0)) tree_i (
        .scores    (scores),
        .class_win (class_win),
        .best      ()
    );

endmodule

// ==== verif/tb_bayes.sv ====
`timescale 1ns/1ns

module tb_bayes import bayes_pkg::*; ();

    localparam int N_RANDOM = 10;
    localparam int N_BURST  = 8;
    localparam int N_PINGS  = 40;
    localparam int N_FRAMES = N_RANDOM + N_BURST + 2 + 1 + N_PINGS;
    localparam int WATCHDOG = N_FRAMES * 40 + 600;  // cycles
    localparam int WAIT_MAX = 200;                  // per reply byte

    logic   clk;
    logic   rst;
    logic   in_we;
    byte_t  in_data;
    logic   in_full;
    logic   out_re;
    byte_t  out_data;
    logic   out_empty;

    log_w_t ref_table [N_CLASS << VOCAB_W];
    int     seed = 32'hf3eb6b08;
    int     errors;
    int     checks;
    logic   saw_full;

    bayes_classifier dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_we     (in_we),
        .in_data   (in_data),
        .in_full   (in_full),
        .out_re    (out_re),
        .out_data  (out_data),
        .out_empty (out_empty)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //==========================================================================
    // host model and checks
    //==========================================================================
    task automatic tick();
        @(posedge clk);
        #1;  // drive and sample just after the edge
    endtask

    task automatic check_val(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic send_byte(input byte_t b);
        while (in_full)
            tick();
        in_we   = 1'b1;
        in_data = b;
        tick();
        in_we   = 1'b0;
    endtask

    // out_data is valid the cycle after out_re
    task automatic read_byte(output byte_t b, output logic ok);
        int waited;
        waited = 0;
        while (out_empty && waited < WAIT_MAX) begin
            tick();
            waited++;
        end
        ok = !out_empty;
        b  = 8'h00;
        if (ok) begin
            out_re = 1'b1;
            tick();
            out_re = 1'b0;
            b      = out_data;
        end else begin
            errors++;
            $display("error: no reply byte arrived within %0d cycles", WAIT_MAX);
        end
    endtask

    // reference scores, lowest wins and a tie goes to the higher class
    function automatic class_t model_winner(input byte_t n, input byte_t words [$]);
        score_t      best;
        score_t      s;
        logic [23:0] sum;
        class_t      win;
        best = '1;
        win  = '0;
        for (int c = 0; c < N_CLASS; c++) begin
            sum = '0;
            foreach (words[i])
                sum = sum + 24'(ref_table[(c << VOCAB_W) + int'(words[i][VOCAB_W-1:0])]);
            s = score_t'(n) * LOG_V[c] - LOG_D[c] - score_t'(sum);
            if (s <= best) begin
                best = s;
                win  = class_t'(c);
            end
        end
        return win;
    endfunction

    task automatic random_words(output byte_t words [$]);
        int n;
        words = {};
        n = 1 + int'($unsigned($random(seed)) % 12);
        for (int i = 0; i < n; i++)
            words.push_back(byte_t'($unsigned($random(seed)) % 16));
    endtask

    task automatic run_frame(input string name, input byte_t n, input byte_t words [$],
                             output byte_t win_byte);
        byte_t  b;
        logic   ok;
        class_t expected;
        expected = model_winner(n, words);
        win_byte = 8'h00;
        send_byte(START_MARK);
        send_byte(n);
        foreach (words[i])
            send_byte(words[i]);
        send_byte(END_MARK);
        read_byte(b, ok);
        if (ok)
            check_val({name, " start"}, START_MARK, b);
        read_byte(win_byte, ok);
        if (ok)
            check_val({name, " class"}, expected, win_byte);
        read_byte(b, ok);
        if (ok)
            check_val({name, " end"}, END_MARK, b);
    endtask

    //==========================================================================
    // stimulus
    //==========================================================================
    initial begin
        byte_t words [$];
        byte_t b;
        byte_t win;
        logic  ok;
        $readmemh(LOG_W_FILE, ref_table);
        errors   = 0;
        checks   = 0;
        saw_full = 1'b0;
        rst      = 1'b0;
        in_we    = 1'b0;
        in_data  = 8'h00;
        out_re   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        tick();
        check_val("reset out_empty", 1, out_empty);
        check_val("reset in_full", 0, in_full);

        send_byte(PING_MARK);
        read_byte(b, ok);
        if (ok)
            check_val("ping reply", PING_REPLY, b);
        repeat (20) tick();
        check_val("ping single byte", 1, out_empty);  // nothing else queued

        for (int f = 0; f < N_RANDOM; f++) begin
            random_words(words);
            run_frame($sformatf("frame %0d", f), byte_t'(words.size()), words, win);
        end

        for (int f = 0; f < N_BURST; f++) begin
            repeat (1 + $unsigned($random(seed)) % 3)
                send_byte(byte_t'($unsigned($random(seed)) % 128));  // idle junk
            random_words(words);
            run_frame($sformatf("burst %0d", f), byte_t'(words.size()), words, win);
        end

        words = {8'h03, 8'h09, 8'h0c};
        run_frame("param n=5", 8'd5, words, win);
        // index 15 puts class 1 and 2 at the same score, high nibble ignored
        words = {8'h3f};
        run_frame("tie", 8'd1, words, win);
        check_val("tie higher class", 2, win);

        fork
            begin
                for (int i = 0; i < N_PINGS; i++)
                    send_byte(PING_MARK);
            end
            begin
                int waited;
                waited = 0;
                while (!in_full && waited < WAIT_MAX) begin
                    tick();
                    waited++;
                end
                saw_full = in_full;
                for (int i = 0; i < N_PINGS; i++) begin
                    read_byte(b, ok);
                    if (ok)
                        check_val($sformatf("backpressure byte %0d", i), PING_REPLY, b);
                end
            end
        join
        checks++;
        assert (saw_full) else begin
            errors++;
            $display("error: in_full never went high while pings were held back");
        end
        repeat (20) tick();
        check_val("backpressure byte count", 1, out_empty);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG);
        $display("summary: %0d checks, %0d errors", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== common/log_w.hex ====
// one 16-bit log_W entry per line, word index 0 to 15 within each class
// entries 0-15 class 0, 16-31 class 1, 32-47 class 2
0190
01a4
0172
01c8
0155
01b0
0188
019a
016e
01d2
0160
01bc
0184
0178
01a0
0064
0170
0188
0196
0150
01b4
0164
017c
01a8
0158
0190
01c0
016a
0182
019e
0174
0064
01b8
01a0
01c4
01d0
0190
01e2
01aa
01bc
01c8
0198
01d8
01b2
01a6
01ca
01c0
00e1

// ==== tb.f ====
common/bayes_pkg.sv
common/word_if.sv
source/sync_fifo.sv
controller/frame_controller.sv
classifier/class_scorer.sv
classifier/min_tree.sv
source/bayes_classifier.sv
verif/tb_bayes.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the tb_bayes simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_bayes -o tb_bayes_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_bayes_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" <<< "$output"; then
    exit 0
fi
exit 1
